//--- verilog/mem_macros.svh
// Sizing of the cache and its backing memory
// Tag, index and offset widths must add up to the 16-bit byte address
// MEM_WORDS must equal 2**(address width - 1), one word per even byte address
// MEM_RD_LAT of at least 1; the controller relies on it for overlapping fills
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

`define MEM_TAG_W 5
`define MEM_IDX_W 8
`define MEM_OFF_W 3

`define MEM_WORDS 32768
`define MEM_BANKS 4

// Cycles from a read command to its data
`define MEM_RD_LAT 2

`endif

//--- verilog/mem_addr_pkg.sv
// Address fields and the data types shared by the cache ways
// Offset bit 0 selects a byte and is always zero for word accesses
`include "mem_macros.svh"

package mem_addr_pkg;

   typedef logic [`MEM_TAG_W-1:0] tag_t;
   typedef logic [`MEM_IDX_W-1:0] idx_t;
   typedef logic [`MEM_OFF_W-1:0] off_t;
   typedef logic [15:0]           word_t;

   typedef enum logic [2:0] {
      WAY_IDLE,
      WAY_CMP_RD,
      WAY_CMP_WR,
      WAY_ACC_RD,
      WAY_ACC_WR
   } way_cmd_e;

   typedef struct packed {
      logic  hit;
      logic  valid;
      logic  dirty;
      tag_t  tag_out;
      word_t data_out;
   } way_status_t;

endpackage

//--- verilog/cache_ctrl_pkg.sv
// Controller state and memory command encodings
// One request in flight; the state list covers the whole miss sequence

package cache_ctrl_pkg;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_COMPARE,
      ST_WB_WORD,
      ST_FILL_REQ,
      ST_FILL_WAIT,
      ST_FILL_DONE,
      ST_ERROR
   } ctrl_state_e;

   // Command to the banked memory, taken in the cycle it is present
   typedef enum logic [1:0] {
      MEM_NONE,
      MEM_READ,
      MEM_WRITE
   } mem_op_e;

endpackage

//--- verilog/way_if.sv
// Command bundle from the controller to both cache ways
// Both ways see the same fields; each has its own enable outside this bundle
`timescale 1ns/1ns

interface way_if;
   import mem_addr_pkg::*;

   tag_t     tag;
   idx_t     idx;
   off_t     off;
   word_t    wdata;
   way_cmd_e cmd;
   logic     set_valid;

   modport ctrl (
      output tag, idx, off, wdata, cmd, set_valid
   );

   modport way (
      input tag, idx, off, wdata, cmd, set_valid
   );

endinterface

//--- verilog/cache_way.sv
// One way of the cache: tag, valid, dirty and a four-word line per set
// Reads are combinational from the index and offset on the bus
// Only valid and dirty bits are cleared by reset; tags and data are not
`timescale 1ns/1ns
`include "mem_macros.svh"

module cache_way (
   input  logic                      clk,
   input  logic                      arst_n,
   input  logic                      enable,
   way_if.way                        wif,
   output mem_addr_pkg::way_status_t status
);
   import mem_addr_pkg::*;

   localparam int SETS       = 2 ** `MEM_IDX_W;
   localparam int WSEL_W     = `MEM_OFF_W - 1;
   localparam int LINE_WORDS = 2 ** WSEL_W;

   tag_t            tag_q  [SETS];
   word_t           data_q [SETS][LINE_WORDS];
   logic [SETS-1:0] valid_q;
   logic [SETS-1:0] dirty_q;

   logic [WSEL_W-1:0] wsel;
   logic              is_cmp;
   logic              tag_eq;
   logic              hit;
   logic              do_cmp_wr;
   logic              do_acc_wr;

   // Word within the line, byte bit dropped
   assign wsel   = wif.off[`MEM_OFF_W-1:1];
   assign is_cmp = (wif.cmd == WAY_CMP_RD) || (wif.cmd == WAY_CMP_WR);
   assign tag_eq = (tag_q[wif.idx] == wif.tag);
   assign hit    = enable && is_cmp && valid_q[wif.idx] && tag_eq;

   // Compare-write only lands on a hit
   assign do_cmp_wr = hit && (wif.cmd == WAY_CMP_WR);
   assign do_acc_wr = enable && (wif.cmd == WAY_ACC_WR);

   always_comb begin
      status.hit      = hit;
      status.valid    = valid_q[wif.idx];
      status.dirty    = dirty_q[wif.idx];
      status.tag_out  = tag_q[wif.idx];
      status.data_out = data_q[wif.idx][wsel];
   end

   always_ff @(posedge clk) begin
      if (do_cmp_wr || do_acc_wr) begin
         data_q[wif.idx][wsel] <= wif.wdata;
      end
      if (do_acc_wr) begin
         tag_q[wif.idx] <= wif.tag;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else if (do_acc_wr) begin
         // Fill word, line is clean and valid once set_valid comes
         valid_q[wif.idx] <= wif.set_valid;
         dirty_q[wif.idx] <= 1'b0;
      end else if (do_cmp_wr) begin
         dirty_q[wif.idx] <= 1'b1;
      end
   end

endmodule

//--- verilog/bank_mem.sv
// Word-interleaved banked memory behind the cache
// Bank is the low address bits; a write lands on its command edge
// Read data and rvalid appear MEM_RD_LAT cycles after the read command
// Contents start at zero through an initial loop, no reset on the array
`timescale 1ns/1ns
`include "mem_macros.svh"

module bank_mem (
   input  logic                           clk,
   input  logic                           arst_n,
   input  cache_ctrl_pkg::mem_op_e        mem_op,
   input  logic [$clog2(`MEM_WORDS)-1:0]  mem_addr,
   input  mem_addr_pkg::word_t            mem_wdata,
   output mem_addr_pkg::word_t            mem_rdata,
   output logic                           mem_rvalid,
   output logic [`MEM_BANKS-1:0]          busy
);
   import mem_addr_pkg::*;
   import cache_ctrl_pkg::*;

   localparam int ADDR_W = $clog2(`MEM_WORDS);
   localparam int BANK_W = $clog2(`MEM_BANKS);
   localparam int ROWS   = `MEM_WORDS / `MEM_BANKS;
   localparam int CNT_W  = $clog2(`MEM_RD_LAT + 1);

   word_t                  mem_q      [`MEM_BANKS][ROWS];
   word_t                  rd_pipe_q  [`MEM_RD_LAT];
   logic [`MEM_RD_LAT-1:0] rv_pipe_q;
   logic [CNT_W-1:0]       busy_cnt_q [`MEM_BANKS];

   logic [BANK_W-1:0]        bank;
   logic [ADDR_W-BANK_W-1:0] row;

   assign bank = mem_addr[BANK_W-1:0];
   assign row  = mem_addr[ADDR_W-1:BANK_W];

   initial begin
      for (int b = 0; b < `MEM_BANKS; b++) begin
         for (int r = 0; r < ROWS; r++) begin
            mem_q[b][r] = '0;
         end
      end
   end

   always @(posedge clk) begin
      if (mem_op == MEM_WRITE) begin
         mem_q[bank][row] <= mem_wdata;
      end
   end

   // Read delay line, data side
   always_ff @(posedge clk) begin
      rd_pipe_q[0] <= mem_q[bank][row];
      for (int i = 1; i < `MEM_RD_LAT; i++) begin
         rd_pipe_q[i] <= rd_pipe_q[i-1];
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rv_pipe_q <= '0;
      end else begin
         rv_pipe_q[0] <= (mem_op == MEM_READ);
         for (int i = 1; i < `MEM_RD_LAT; i++) begin
            rv_pipe_q[i] <= rv_pipe_q[i-1];
         end
      end
   end

   assign mem_rdata  = rd_pipe_q[`MEM_RD_LAT-1];
   assign mem_rvalid = rv_pipe_q[`MEM_RD_LAT-1];

   // Per-bank busy window after any command
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int b = 0; b < `MEM_BANKS; b++) begin
            busy_cnt_q[b] <= '0;
         end
      end else begin
         for (int b = 0; b < `MEM_BANKS; b++) begin
            if ((mem_op != MEM_NONE) && (bank == BANK_W'(b))) begin
               busy_cnt_q[b] <= CNT_W'(`MEM_RD_LAT);
            end else if (busy_cnt_q[b] != '0) begin
               busy_cnt_q[b] <= busy_cnt_q[b] - 1'b1;
            end
         end
      end
   end

   always_comb begin
      for (int b = 0; b < `MEM_BANKS; b++) begin
         busy[b] = (busy_cnt_q[b] != '0);
      end
   end

endmodule

//--- verilog/cache_ctrl.sv
// Cache controller, one request in flight
// A hit finishes one cycle after acceptance; a miss writes back a dirty
// victim, fills the line in four reads and then repeats the access
// Victim choice takes an invalid way first, way 0 before way 1, else the victim bit
// New requests are ignored outside idle
`timescale 1ns/1ns
`include "mem_macros.svh"

module cache_ctrl (
   input  logic                           clk,
   input  logic                           arst_n,
   input  logic [15:0]                    addr,
   input  mem_addr_pkg::word_t            data_in,
   input  logic                           rd,
   input  logic                           wr,
   way_if.ctrl                            wif,
   output logic                           en0,
   output logic                           en1,
   input  mem_addr_pkg::way_status_t      st0,
   input  mem_addr_pkg::way_status_t      st1,
   output cache_ctrl_pkg::mem_op_e        mem_op,
   output logic [$clog2(`MEM_WORDS)-1:0]  mem_addr,
   output mem_addr_pkg::word_t            mem_wdata,
   input  mem_addr_pkg::word_t            mem_rdata,
   input  logic                           mem_rvalid,
   output mem_addr_pkg::word_t            data_out,
   output logic                           done,
   output logic                           stall,
   output logic                           cache_hit,
   output logic                           req_err
);
   import mem_addr_pkg::*;
   import cache_ctrl_pkg::*;

   localparam int WSEL_W = `MEM_OFF_W - 1;

   ctrl_state_e state_q;
   ctrl_state_e state_d;

   tag_t  req_tag_q;
   idx_t  req_idx_q;
   off_t  req_off_q;
   word_t req_data_q;
   logic  req_wr_q;

   logic [WSEL_W-1:0] mem_cnt_q;
   logic [WSEL_W-1:0] rcv_cnt_q;
   logic              sel_way_q;
   logic              victim_q;

   logic        bad_req;
   logic        any_hit;
   logic        victim_way;
   way_status_t cand_st;
   way_status_t sel_st;
   way_cmd_e    cmp_cmd;

   assign bad_req    = (rd && wr) || addr[0];
   assign any_hit    = st0.hit || st1.hit;
   assign victim_way = !st0.valid ? 1'b0 : (!st1.valid ? 1'b1 : victim_q);
   assign cand_st    = victim_way ? st1 : st0;
   assign sel_st     = sel_way_q ? st1 : st0;
   assign cmp_cmd    = req_wr_q ? WAY_CMP_WR : WAY_CMP_RD;

   // Only the enabled way can hit, so this covers the repeat after a fill
   assign data_out = st0.hit ? st0.data_out : st1.data_out;

   always_ff @(posedge clk) begin
      if ((state_q == ST_IDLE) && (rd || wr)) begin
         {req_tag_q, req_idx_q, req_off_q} <= addr;
         req_data_q <= data_in;
         req_wr_q   <= wr;
      end
   end

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: begin
            if (rd || wr) begin
               state_d = bad_req ? ST_ERROR : ST_COMPARE;
            end
         end
         ST_COMPARE: begin
            if (any_hit) begin
               state_d = ST_IDLE;
            end else if (cand_st.valid && cand_st.dirty) begin
               state_d = ST_WB_WORD;
            end else begin
               state_d = ST_FILL_REQ;
            end
         end
         ST_WB_WORD: begin
            if (mem_cnt_q == '1) begin
               state_d = ST_FILL_REQ;
            end
         end
         ST_FILL_REQ: begin
            if (mem_cnt_q == '1) begin
               state_d = ST_FILL_WAIT;
            end
         end
         ST_FILL_WAIT: begin
            if (mem_rvalid && (rcv_cnt_q == '1)) begin
               state_d = ST_FILL_DONE;
            end
         end
         default: state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state_q   <= ST_IDLE;
         mem_cnt_q <= '0;
         rcv_cnt_q <= '0;
         sel_way_q <= 1'b0;
         victim_q  <= 1'b0;
      end else begin
         state_q <= state_d;
         case (state_q)
            ST_COMPARE: begin
               if (!any_hit) begin
                  mem_cnt_q <= '0;
                  rcv_cnt_q <= '0;
                  sel_way_q <= victim_way;
                  // Flip only when a valid line gets replaced
                  if (st0.valid && st1.valid) begin
                     victim_q <= ~victim_q;
                  end
               end
            end
            ST_WB_WORD, ST_FILL_REQ: mem_cnt_q <= mem_cnt_q + 1'b1;
            default: ;
         endcase
         if (mem_rvalid) begin
            rcv_cnt_q <= rcv_cnt_q + 1'b1;
         end
      end
   end

   // Way commands
   always_comb begin
      en0           = 1'b0;
      en1           = 1'b0;
      wif.tag       = req_tag_q;
      wif.idx       = req_idx_q;
      wif.off       = req_off_q;
      wif.wdata     = req_data_q;
      wif.cmd       = WAY_IDLE;
      wif.set_valid = 1'b0;
      case (state_q)
         ST_COMPARE: begin
            en0     = 1'b1;
            en1     = 1'b1;
            wif.cmd = cmp_cmd;
         end
         ST_WB_WORD: begin
            en0     = ~sel_way_q;
            en1     = sel_way_q;
            wif.cmd = WAY_ACC_RD;
            wif.off = {mem_cnt_q, 1'b0};
         end
         ST_FILL_REQ, ST_FILL_WAIT: begin
            if (mem_rvalid) begin
               en0           = ~sel_way_q;
               en1           = sel_way_q;
               wif.cmd       = WAY_ACC_WR;
               wif.off       = {rcv_cnt_q, 1'b0};
               wif.wdata     = mem_rdata;
               wif.set_valid = (rcv_cnt_q == '1);
            end
         end
         ST_FILL_DONE: begin
            en0     = ~sel_way_q;
            en1     = sel_way_q;
            wif.cmd = cmp_cmd;
         end
         default: ;
      endcase
   end

   // Memory command and handshake
   always_comb begin
      mem_op    = MEM_NONE;
      mem_addr  = {req_tag_q, req_idx_q, mem_cnt_q};
      mem_wdata = sel_st.data_out;
      done      = 1'b0;
      cache_hit = 1'b0;
      req_err   = 1'b0;
      case (state_q)
         ST_COMPARE: begin
            done      = any_hit;
            cache_hit = any_hit;
         end
         ST_WB_WORD: begin
            mem_op   = MEM_WRITE;
            mem_addr = {sel_st.tag_out, req_idx_q, mem_cnt_q};
         end
         ST_FILL_REQ: mem_op = MEM_READ;
         ST_FILL_DONE: done = 1'b1;
         ST_ERROR: begin
            done    = 1'b1;
            req_err = 1'b1;
         end
         default: ;
      endcase
   end

   // Busy with a miss from the compare cycle until the fill completes
   assign stall = (state_q == ST_WB_WORD) || (state_q == ST_FILL_REQ) ||
                  (state_q == ST_FILL_WAIT) || ((state_q == ST_COMPARE) && !any_hit);

endmodule

//--- verilog/mem_system.sv
// Two-way set-associative write-back data cache with its backing memory
// 16-bit byte address, word accesses only; odd addresses report err
// Hold Rd or Wr with Addr and DataIn until Done; no back-pressure
`timescale 1ns/1ns
`include "mem_macros.svh"

module mem_system (
   input  logic        clk,
   input  logic        arst_n,
   input  logic [15:0] Addr,
   input  logic [15:0] DataIn,
   input  logic        Rd,
   input  logic        Wr,
   output logic [15:0] DataOut,
   output logic        Done,
   output logic        Stall,
   output logic        CacheHit,
   output logic        err
);
   import mem_addr_pkg::*;
   import cache_ctrl_pkg::*;

   logic                          en0;
   logic                          en1;
   way_status_t                   st0;
   way_status_t                   st1;
   mem_op_e                       mem_op;
   logic [$clog2(`MEM_WORDS)-1:0] mem_addr;
   word_t                         mem_wdata;
   word_t                         mem_rdata;
   logic                          mem_rvalid;
   logic [`MEM_BANKS-1:0]         busy;
   logic                          req_err;

   way_if wif ();

   cache_ctrl ctrl (
      .clk        (clk),
      .arst_n     (arst_n),
      .addr       (Addr),
      .data_in    (DataIn),
      .rd         (Rd),
      .wr         (Wr),
      .wif        (wif.ctrl),
      .en0        (en0),
      .en1        (en1),
      .st0        (st0),
      .st1        (st1),
      .mem_op     (mem_op),
      .mem_addr   (mem_addr),
      .mem_wdata  (mem_wdata),
      .mem_rdata  (mem_rdata),
      .mem_rvalid (mem_rvalid),
      .data_out   (DataOut),
      .done       (Done),
      .stall      (Stall),
      .cache_hit  (CacheHit),
      .req_err    (req_err)
   );

   cache_way way0 (
      .clk    (clk),
      .arst_n (arst_n),
      .enable (en0),
      .wif    (wif.way),
      .status (st0)
   );

   cache_way way1 (
      .clk    (clk),
      .arst_n (arst_n),
      .enable (en1),
      .wif    (wif.way),
      .status (st1)
   );

   // Busy is observed by the protocol checks only
   bank_mem mem (
      .clk        (clk),
      .arst_n     (arst_n),
      .mem_op     (mem_op),
      .mem_addr   (mem_addr),
      .mem_wdata  (mem_wdata),
      .mem_rdata  (mem_rdata),
      .mem_rvalid (mem_rvalid),
      .busy       (busy)
   );

   assign err = req_err;

endmodule

//--- tests/tb_clock.sv
// Free-running clock and active-low reset for the testbench
// Reset releases 1 ns after a rising edge, in step with the stimulus
`timescale 1ns/1ns

module tb_clock #(
   parameter int PERIOD_NS    = 8,
   parameter int RESET_CYCLES = 8
) (
   output logic clk,
   output logic arst_n
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   initial begin
      arst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      arst_n = 1'b1;
   end

endmodule

//--- tests/mem_system_assertions.sv
// Protocol checks on the cache handshake and the banked memory port
// Attached to every mem_system instance; inactive while reset is low
`timescale 1ns/1ns
`include "mem_macros.svh"

module mem_system_assertions (
   input logic                          clk,
   input logic                          arst_n,
   input logic                          done,
   input logic                          stall,
   input cache_ctrl_pkg::mem_op_e       mem_op,
   input logic [$clog2(`MEM_WORDS)-1:0] mem_addr,
   input logic                          mem_rvalid,
   input logic [`MEM_BANKS-1:0]         busy
);
   import cache_ctrl_pkg::*;

   localparam int BANK_W = $clog2(`MEM_BANKS);

   logic [BANK_W-1:0] bank;

   assign bank = mem_addr[BANK_W-1:0];

   a_done_pulse: assert property (@(posedge clk) disable iff (!arst_n) done |=> !done)
      else $error("Done stayed high for two cycles");

   a_stall_done: assert property (@(posedge clk) disable iff (!arst_n) done |-> !stall)
      else $error("Stall high together with Done");

   // Read data returns a fixed number of cycles after its command, never otherwise
   a_rvalid_lat: assert property (@(posedge clk) disable iff (!arst_n)
      mem_rvalid == $past(mem_op == MEM_READ, `MEM_RD_LAT))
      else $error("mem_rvalid does not follow a read by the memory latency");

   a_bank_free: assert property (@(posedge clk) disable iff (!arst_n)
      (mem_op != MEM_NONE) |-> !busy[bank])
      else $error("Memory bank addressed while busy");

endmodule

bind mem_system mem_system_assertions checks (
   .clk        (clk),
   .arst_n     (arst_n),
   .done       (Done),
   .stall      (Stall),
   .mem_op     (mem_op),
   .mem_addr   (mem_addr),
   .mem_rvalid (mem_rvalid),
   .busy       (busy)
);

//--- tests/mem_system_tb.sv
// Directed and random requests against a reference model of the cache
// The model tracks data, per-set tags and valid bits, and the victim bit
// Inputs change 1 ns after the rising edge, responses are sampled on the falling edge
`timescale 1ns/1ns
`include "mem_macros.svh"

module mem_system_tb;

   localparam int CLK_PERIOD    = 8;
   localparam int RESET_CYCLES  = 8;
   localparam int DIRECTED_REQS = 24;
   localparam int RAND_REQS     = 240;
   localparam int MAX_REQS      = DIRECTED_REQS + RAND_REQS;
   localparam int REQ_CYCLES    = 200;
   localparam int SETS          = 2 ** `MEM_IDX_W;

   logic        clk;
   logic        arst_n;
   logic [15:0] addr;
   logic [15:0] data_in;
   logic        rd;
   logic        wr;
   logic [15:0] data_out;
   logic        done;
   logic        stall;
   logic        cache_hit;
   logic        err;

   // Reference model
   logic [15:0]           shadow    [`MEM_WORDS];
   logic [`MEM_TAG_W-1:0] ref_tag   [SETS][2];
   logic                  ref_valid [SETS][2];
   logic                  ref_victim;

   // Expected response of the request in flight
   logic        exp_pending = 1'b0;
   logic        exp_is_rd;
   logic        exp_hit;
   logic        exp_err;
   logic [15:0] exp_data;

   int   issued       = 0;
   int   checked_reqs = 0;
   int   checks       = 0;
   int   errors       = 0;
   int   wait_cycles  = 0;
   logic timed_out    = 1'b0;

   tb_clock #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) clock_gen (
      .clk    (clk),
      .arst_n (arst_n)
   );

   mem_system dut (
      .clk      (clk),
      .arst_n   (arst_n),
      .Addr     (addr),
      .DataIn   (data_in),
      .Rd       (rd),
      .Wr       (wr),
      .DataOut  (data_out),
      .Done     (done),
      .Stall    (stall),
      .CacheHit (cache_hit),
      .err      (err)
   );

   task automatic check_value(input string name, input logic [15:0] actual,
                              input logic [15:0] expected);
      checks = checks + 1;
      if (actual !== expected) begin
         errors = errors + 1;
         $display("ERROR at %0t ns: %s is 0x%04h, expected 0x%04h",
                  $time, name, actual, expected);
      end
   endtask

   task automatic clear_model();
      for (int w = 0; w < `MEM_WORDS; w++) begin
         shadow[w] = 16'h0000;
      end
      for (int s = 0; s < SETS; s++) begin
         ref_valid[s][0] = 1'b0;
         ref_valid[s][1] = 1'b0;
         ref_tag[s][0]   = '0;
         ref_tag[s][1]   = '0;
      end
      ref_victim = 1'b0;
   endtask

   // Applies one legal access to the model, returns the word the DUT should show
   function automatic logic [15:0] ref_access(input logic is_wr, input logic [15:0] a,
                                              input logic [15:0] wdata, output logic hit);
      logic [`MEM_TAG_W-1:0] tag;
      logic [`MEM_IDX_W-1:0] idx;
      logic                  way;
      tag = a[15:16-`MEM_TAG_W];
      idx = a[`MEM_OFF_W+`MEM_IDX_W-1:`MEM_OFF_W];
      hit = 1'b0;
      way = 1'b0;
      for (int w = 0; w < 2; w++) begin
         if (ref_valid[idx][w] && (ref_tag[idx][w] == tag)) begin
            hit = 1'b1;
         end
      end
      if (!hit) begin
         // Invalid way first, way 0 before way 1
         if (!ref_valid[idx][0]) begin
            way = 1'b0;
         end else if (!ref_valid[idx][1]) begin
            way = 1'b1;
         end else begin
            way        = ref_victim;
            ref_victim = ~ref_victim;
         end
         ref_valid[idx][way] = 1'b1;
         ref_tag[idx][way]   = tag;
      end
      if (is_wr) begin
         shadow[a[15:1]] = wdata;
      end
      return shadow[a[15:1]];
   endfunction

   function automatic logic [15:0] make_addr(input logic [`MEM_TAG_W-1:0] tag,
                                             input logic [`MEM_IDX_W-1:0] idx,
                                             input logic [`MEM_OFF_W-2:0] word);
      return {tag, idx, word, 1'b0};
   endfunction

   // Called 1 ns after a rising edge; returns at the same phase
   task automatic issue_request(input logic is_rd, input logic is_wr,
                                input logic [15:0] a, input logic [15:0] wdata);
      logic        hit;
      logic [15:0] expected;
      if ((is_rd && is_wr) || a[0]) begin
         exp_err   = 1'b1;
         exp_hit   = 1'b0;
         exp_is_rd = 1'b0;
         exp_data  = 16'h0000;
      end else begin
         expected  = ref_access(is_wr, a, wdata, hit);
         exp_err   = 1'b0;
         exp_hit   = hit;
         exp_is_rd = is_rd;
         exp_data  = expected;
      end
      exp_pending = 1'b1;
      issued      = issued + 1;
      addr        = a;
      data_in     = wdata;
      rd          = is_rd;
      wr          = is_wr;
      do begin
         @(negedge clk);
      end while (!done);
      @(posedge clk);
      #1;
      rd          = 1'b0;
      wr          = 1'b0;
      exp_pending = 1'b0;
   endtask

   task automatic finish_run();
      $display("Requests issued: %0d, checked: %0d, checks: %0d, errors: %0d",
               issued, checked_reqs, checks, errors);
      if ((errors == 0) && !timed_out && (checked_reqs == issued)) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   endtask

   // Compare process
   always @(negedge clk) begin
      if (exp_pending) begin
         wait_cycles = wait_cycles + 1;
      end
      if (arst_n && !done) begin
         // Stall holds from the cycle after acceptance until Done
         if (exp_pending && (wait_cycles > 1)) begin
            check_value("Stall", 16'(stall), 16'd1);
         end else begin
            check_value("Stall", 16'(stall), 16'd0);
         end
      end
      if (arst_n && done) begin
         if (!exp_pending) begin
            errors = errors + 1;
            $display("Done pulse at %0t ns with no request outstanding", $time);
         end else begin
            check_value("err", 16'(err), 16'(exp_err));
            check_value("CacheHit", 16'(cache_hit), 16'(exp_hit));
            check_value("Stall", 16'(stall), 16'd0);
            if (exp_is_rd && !exp_err) begin
               check_value("DataOut", data_out, exp_data);
            end
            // Hits and rejected requests finish one cycle after acceptance
            if (exp_hit || exp_err) begin
               check_value("Done latency", 16'(wait_cycles), 16'd2);
            end
         end
         wait_cycles  = 0;
         checked_reqs = checked_reqs + 1;
      end
   end

   // Watchdog allows 200 cycles per request
   initial begin
      #(CLK_PERIOD * (RESET_CYCLES + REQ_CYCLES * MAX_REQS));
      timed_out = 1'b1;
      $display("Watchdog expired at %0t ns, a request never completed", $time);
      finish_run();
   end

   initial begin
      logic [31:0] r;
      addr    = 16'h0000;
      data_in = 16'h0000;
      rd      = 1'b0;
      wr      = 1'b0;
      void'($urandom(32'hb4d4_50f3));
      clear_model();
      wait (arst_n === 1'b1);
      @(posedge clk);
      #1;

      // Cold misses return zero, then a hit on the same line
      issue_request(1'b1, 1'b0, 16'h0a40, 16'h0000);
      issue_request(1'b1, 1'b0, 16'h0a46, 16'h0000);
      issue_request(1'b1, 1'b0, 16'hf3a8, 16'h0000);

      // Write allocate and read back
      issue_request(1'b0, 1'b1, 16'h2a10, 16'hbeef);
      issue_request(1'b1, 1'b0, 16'h2a10, 16'h0000);
      issue_request(1'b1, 1'b0, 16'h2a12, 16'h0000);
      issue_request(1'b0, 1'b1, 16'h0a44, 16'hc0de);
      issue_request(1'b1, 1'b0, 16'h0a44, 16'h0000);

      // Three tags in set 0x5c force dirty evictions
      issue_request(1'b0, 1'b1, make_addr(5'd1, 8'h5c, 2'd0), 16'h1111);
      issue_request(1'b0, 1'b1, make_addr(5'd1, 8'h5c, 2'd3), 16'h1313);
      issue_request(1'b0, 1'b1, make_addr(5'd2, 8'h5c, 2'd1), 16'h2222);
      issue_request(1'b0, 1'b1, make_addr(5'd3, 8'h5c, 2'd2), 16'h3333);
      issue_request(1'b1, 1'b0, make_addr(5'd1, 8'h5c, 2'd0), 16'h0000);
      issue_request(1'b1, 1'b0, make_addr(5'd1, 8'h5c, 2'd3), 16'h0000);
      issue_request(1'b1, 1'b0, make_addr(5'd2, 8'h5c, 2'd1), 16'h0000);
      issue_request(1'b1, 1'b0, make_addr(5'd3, 8'h5c, 2'd2), 16'h0000);

      // Rejected requests leave the data alone
      issue_request(1'b0, 1'b1, 16'h3330, 16'h5a5a);
      issue_request(1'b1, 1'b0, 16'h3330, 16'h0000);
      issue_request(1'b1, 1'b0, 16'h3331, 16'h0000);
      issue_request(1'b0, 1'b1, 16'h3331, 16'hdead);
      issue_request(1'b1, 1'b1, 16'h3330, 16'hdead);
      issue_request(1'b1, 1'b0, 16'h3330, 16'h0000);
      issue_request(1'b0, 1'b1, 16'h7771, 16'hdead);
      issue_request(1'b1, 1'b0, 16'h7770, 16'h0000);

      // Four tags over four sets keeps misses and evictions frequent
      for (int i = 0; i < RAND_REQS; i++) begin
         r = $urandom;
         issue_request(!r[6], r[6], make_addr(5'(r[1:0]), 8'h40 | 8'(r[3:2]), r[5:4]),
                       r[31:16]);
      end

      repeat (4) @(posedge clk);
      finish_run();
   end

endmodule

//--- list.f
+incdir+verilog
verilog/mem_addr_pkg.sv
verilog/cache_ctrl_pkg.sv
verilog/way_if.sv
verilog/cache_way.sv
verilog/bank_mem.sv
verilog/cache_ctrl.sv
verilog/mem_system.sv
tests/tb_clock.sv
tests/mem_system_assertions.sv
tests/mem_system_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the cache regression with Verilator and run it from the project root
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert \
   --top-module mem_system_tb --Mdir "$build_dir" -o mem_system_sim -f list.f
build_status=$?
if [ $build_status -ne 0 ]; then
   echo "Verilator build failed with status $build_status"
   exit 1
fi

"./$build_dir/mem_system_sim" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

if grep -q "Regression failed" "$log_file"; then
   exit 1
fi
exit 0
